/* fir_pkg.sv */
package fir_pkg;

    // --------------------
    // widths
    // --------------------
    localparam int DATA_W = 32;
    localparam int ADDR_W = 12;

    // --------------------
    // register map
    // --------------------
    localparam logic [ADDR_W-1:0] ADDR_CTRL      = 12'h000;
    localparam logic [ADDR_W-1:0] ADDR_LEN       = 12'h010;
    localparam logic [ADDR_W-1:0] ADDR_TAPS      = 12'h014;
    // coefficient i at ADDR_COEF_BASE + 4*i
    localparam logic [ADDR_W-1:0] ADDR_COEF_BASE = 12'h080;

    // control register bits
    localparam int CTRL_START = 0;
    localparam int CTRL_DONE  = 1;
    localparam int CTRL_IDLE  = 2;

    // --------------------
    // payload types
    // --------------------
    typedef logic signed [DATA_W-1:0] coef_t;
    typedef logic signed [DATA_W-1:0] sample_t;
    // sums wrap at 32 bits
    typedef logic signed [DATA_W-1:0] acc_t;

endpackage

/* fir_ram.sv */
module fir_ram #(
    parameter type word_t = logic [31:0],
    parameter int  DEPTH  = 32
) (
    input  logic                     axis_clk,
    input  logic                     en,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] addr,
    input  word_t                    din,
    output word_t                    dout
);

    word_t mem [DEPTH];

    // write-first, the new word shows on dout next cycle
    always_ff @(posedge axis_clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= din;
                dout      <= din;
            end else begin
                dout <= mem[addr];
            end
        end
    end

endmodule

/* fir_regs.sv */
module fir_regs #(
    parameter int MAX_TAPS = 32
) (
    input  logic                             axis_clk,
    input  logic                             axis_rst_n,
    input  logic                             awvalid,
    output logic                             awready,
    input  logic [fir_pkg::ADDR_W-1:0]       awaddr,
    input  logic                             wvalid,
    output logic                             wready,
    input  logic [fir_pkg::DATA_W-1:0]       wdata,
    input  logic                             arvalid,
    output logic                             arready,
    input  logic [fir_pkg::ADDR_W-1:0]       araddr,
    output logic                             rvalid,
    input  logic                             rready,
    output logic [fir_pkg::DATA_W-1:0]       rdata,
    output logic                             start,
    output logic [fir_pkg::DATA_W-1:0]       data_length,
    output logic [$clog2(MAX_TAPS+1)-1:0]    tap_num,
    input  logic                             busy,
    input  logic                             done,
    input  logic [$clog2(MAX_TAPS)-1:0]      tap_idx,
    output fir_pkg::coef_t                   tap_coef
);
    import fir_pkg::*;

    localparam int IDX_W = $clog2(MAX_TAPS);
    localparam int CNT_W = $clog2(MAX_TAPS+1);

    logic              aw_pend;
    logic [ADDR_W-1:0] aw_addr;
    logic              ar_pend;
    logic              rd_live;
    logic              rd_coef;
    logic [DATA_W-1:0] rd_reg;
    logic [DATA_W-1:0] rd_val;
    logic              done_q;
    logic              wr_fire;
    logic              ar_fire;
    logic              coef_en;
    logic              coef_we;
    logic [IDX_W-1:0]  coef_addr;

    function automatic logic is_coef(input logic [ADDR_W-1:0] a);
        return (a >= ADDR_COEF_BASE) && (a < ADDR_COEF_BASE + 4 * MAX_TAPS);
    endfunction

    function automatic logic [IDX_W-1:0] coef_idx(input logic [ADDR_W-1:0] a);
        logic [ADDR_W-1:0] off;
        off = a - ADDR_COEF_BASE;
        return off[IDX_W+1:2];
    endfunction

    // --------------------
    // control port handshakes
    // --------------------
    assign awready = !aw_pend;
    assign wready  = aw_pend;
    assign arready = !ar_pend;
    assign rvalid  = ar_pend;
    assign wr_fire = wvalid && wready;
    assign ar_fire = arvalid && arready;

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            aw_pend <= 1'b0;
            ar_pend <= 1'b0;
            rd_live <= 1'b0;
        end else begin
            if (awvalid && awready) begin
                aw_pend <= 1'b1;
            end else if (wr_fire) begin
                aw_pend <= 1'b0;
            end
            if (ar_fire) begin
                ar_pend <= 1'b1;
            end else if (rvalid && rready) begin
                ar_pend <= 1'b0;
            end
            rd_live <= ar_fire;
        end
    end

    // coef data lands a cycle after the address and is then held in rd_reg
    assign rdata = (rd_live && rd_coef) ? tap_coef : rd_reg;

    always_comb begin
        rd_val = '0;
        case (araddr)
            ADDR_CTRL: begin
                rd_val[CTRL_DONE] = done_q;
                rd_val[CTRL_IDLE] = !busy;
            end
            ADDR_LEN:  rd_val = data_length;
            ADDR_TAPS: rd_val[CNT_W-1:0] = tap_num;
            default:   rd_val = '0;
        endcase
    end

    always_ff @(posedge axis_clk) begin
        if (awvalid && awready) begin
            aw_addr <= awaddr;
        end
        if (ar_fire) begin
            rd_reg  <= rd_val;
            rd_coef <= !busy && is_coef(araddr);
        end else if (rd_live) begin
            rd_reg <= rdata;
        end
    end

    // --------------------
    // configuration
    // --------------------
    assign start = wr_fire && !busy && (aw_addr == ADDR_CTRL) && wdata[CTRL_START];

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            data_length <= '0;
            tap_num     <= '0;
            done_q      <= 1'b0;
        end else begin
            if (wr_fire && !busy && aw_addr == ADDR_LEN) begin
                data_length <= wdata;
            end
            if (wr_fire && !busy && aw_addr == ADDR_TAPS) begin
                tap_num <= wdata[CNT_W-1:0];
            end
            // sticky until software reads ctrl
            if (done) begin
                done_q <= 1'b1;
            end else if (ar_fire && araddr == ADDR_CTRL) begin
                done_q <= 1'b0;
            end
        end
    end

    // --------------------
    // coefficient store
    // --------------------
    assign coef_we = wr_fire && !busy && is_coef(aw_addr);
    assign coef_en = busy || coef_we || (ar_fire && is_coef(araddr));

    always_comb begin
        if (busy) begin
            coef_addr = tap_idx;
        end else if (coef_we) begin
            coef_addr = coef_idx(aw_addr);
        end else begin
            coef_addr = coef_idx(araddr);
        end
    end

    fir_ram #(
        .word_t (coef_t),
        .DEPTH  (MAX_TAPS)
    ) i_coef_ram (
        .axis_clk (axis_clk),
        .en       (coef_en),
        .we       (coef_we),
        .addr     (coef_addr),
        .din      (coef_t'(wdata)),
        .dout     (tap_coef)
    );

endmodule

/* fir_sequencer.sv */
module fir_sequencer #(
    parameter int MAX_TAPS = 32
) (
    input  logic                          axis_clk,
    input  logic                          axis_rst_n,
    input  logic                          start,
    input  logic [fir_pkg::DATA_W-1:0]    data_length,
    input  logic [$clog2(MAX_TAPS+1)-1:0] tap_num,
    output logic                          busy,
    output logic                          done,
    output logic [$clog2(MAX_TAPS)-1:0]   tap_idx,
    input  logic                          ss_tvalid,
    input  fir_pkg::sample_t              ss_tdata,
    output logic                          ss_tready,
    output logic                          sm_tvalid,
    input  logic                          sm_tready,
    output logic                          sm_tlast,
    output logic                          step,
    output logic                          first,
    output fir_pkg::sample_t              hist_sample
);
    import fir_pkg::*;

    localparam int IDX_W = $clog2(MAX_TAPS);
    localparam int CNT_W = $clog2(MAX_TAPS+1);

    typedef enum logic [2:0] {
        S_IDLE,
        S_CLR,
        S_WAIT,
        S_STEP,
        S_RES,
        S_OUT
    } state_t;

    state_t            state;
    logic [IDX_W-1:0]  idx;
    logic [IDX_W-1:0]  wptr;
    logic [IDX_W-1:0]  wptr_nxt;
    logic [IDX_W-1:0]  hist_addr;
    logic [CNT_W-1:0]  tap_last;
    logic              last_tap;
    logic [DATA_W-1:0] in_cnt;
    logic              hist_we;

    // --------------------
    // strobes
    // --------------------
    assign busy      = (state != S_IDLE);
    assign ss_tready = (state == S_WAIT);
    assign sm_tvalid = (state == S_OUT);
    assign sm_tlast  = (state == S_OUT) && (in_cnt == data_length);
    assign first     = (state == S_WAIT) && ss_tvalid;
    assign step      = first || (state == S_STEP);
    assign tap_idx   = idx;

    assign tap_last = tap_num - 1'b1;
    assign last_tap = (CNT_W'(idx) == tap_last);
    assign wptr_nxt = (CNT_W'(wptr) == tap_last) ? '0 : wptr + 1'b1;

    // history slot for tap i is (wptr - i) mod tap_num
    always_comb begin
        if (state == S_CLR) begin
            hist_addr = idx;
        end else if (idx <= wptr) begin
            hist_addr = wptr - idx;
        end else begin
            hist_addr = IDX_W'(CNT_W'(wptr) + tap_num - CNT_W'(idx));
        end
    end

    assign hist_we = (state == S_CLR) || first;

    // --------------------
    // run control
    // --------------------
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            state  <= S_IDLE;
            idx    <= '0;
            wptr   <= '0;
            in_cnt <= '0;
            done   <= 1'b0;
        end else begin
            done <= sm_tlast && sm_tready;
            if (first) begin
                in_cnt <= in_cnt + 1'b1;
            end
            case (state)
                S_IDLE: begin
                    if (start) begin
                        state  <= S_CLR;
                        idx    <= '0;
                        wptr   <= '0;
                        in_cnt <= '0;
                    end
                end
                S_CLR: begin
                    if (idx == IDX_W'(MAX_TAPS - 1)) begin
                        state <= S_WAIT;
                        idx   <= '0;
                    end else begin
                        idx <= idx + 1'b1;
                    end
                end
                S_WAIT, S_STEP: begin
                    if (step && last_tap) begin
                        state <= S_RES;
                        idx   <= '0;
                        wptr  <= wptr_nxt;
                    end else if (step) begin
                        state <= S_STEP;
                        idx   <= idx + 1'b1;
                    end
                end
                // drain the mac pipeline
                S_RES: begin
                    if (idx == IDX_W'(2)) begin
                        state <= S_OUT;
                        idx   <= '0;
                    end else begin
                        idx <= idx + 1'b1;
                    end
                end
                S_OUT: begin
                    if (sm_tready) begin
                        state <= sm_tlast ? S_IDLE : S_WAIT;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    fir_ram #(
        .word_t (sample_t),
        .DEPTH  (MAX_TAPS)
    ) i_hist_ram (
        .axis_clk (axis_clk),
        .en       (busy),
        .we       (hist_we),
        .addr     (hist_addr),
        .din      ((state == S_CLR) ? sample_t'(0) : ss_tdata),
        .dout     (hist_sample)
    );

endmodule

/* fir_mac.sv */
module fir_mac (
    input  logic             axis_clk,
    input  logic             axis_rst_n,
    input  logic             step,
    input  logic             first,
    input  fir_pkg::coef_t   tap_coef,
    input  fir_pkg::sample_t hist_sample,
    output fir_pkg::acc_t    acc
);
    import fir_pkg::*;

    logic    step_d;
    logic    first_d;
    logic    op_vld;
    logic    op_first;
    logic    prod_vld;
    logic    prod_first;
    coef_t   h_q;
    sample_t x_q;
    acc_t    prod;

    // valid/first follow the data through ram, operand and product stages
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            step_d     <= 1'b0;
            first_d    <= 1'b0;
            op_vld     <= 1'b0;
            op_first   <= 1'b0;
            prod_vld   <= 1'b0;
            prod_first <= 1'b0;
        end else begin
            step_d     <= step;
            first_d    <= first;
            op_vld     <= step_d;
            op_first   <= first_d;
            prod_vld   <= op_vld;
            prod_first <= op_first;
        end
    end

    always_ff @(posedge axis_clk) begin
        if (step_d) begin
            h_q <= tap_coef;
            x_q <= hist_sample;
        end
        if (op_vld) begin
            prod <= h_q * x_q;
        end
        // load on the first term, hold between samples
        if (prod_vld) begin
            acc <= prod_first ? prod : acc + prod;
        end
    end

endmodule

/* fir.sv */
module fir #(
    parameter int MAX_TAPS = 32
) (
    input  logic                       axis_clk,
    input  logic                       axis_rst_n,
    input  logic                       awvalid,
    output logic                       awready,
    input  logic [fir_pkg::ADDR_W-1:0] awaddr,
    input  logic                       wvalid,
    output logic                       wready,
    input  logic [fir_pkg::DATA_W-1:0] wdata,
    input  logic                       arvalid,
    output logic                       arready,
    input  logic [fir_pkg::ADDR_W-1:0] araddr,
    output logic                       rvalid,
    input  logic                       rready,
    output logic [fir_pkg::DATA_W-1:0] rdata,
    input  logic                       ss_tvalid,
    input  fir_pkg::sample_t           ss_tdata,
    output logic                       ss_tready,
    output logic                       sm_tvalid,
    input  logic                       sm_tready,
    output fir_pkg::acc_t              sm_tdata,
    output logic                       sm_tlast
);
    import fir_pkg::*;

    logic                          start;
    logic [DATA_W-1:0]             data_length;
    logic [$clog2(MAX_TAPS+1)-1:0] tap_num;
    logic                          busy;
    logic                          done;
    logic [$clog2(MAX_TAPS)-1:0]   tap_idx;
    coef_t                         tap_coef;
    logic                          step;
    logic                          first;
    sample_t                       hist_sample;

    fir_regs #(
        .MAX_TAPS (MAX_TAPS)
    ) i_regs (
        .axis_clk    (axis_clk),
        .axis_rst_n  (axis_rst_n),
        .awvalid     (awvalid),
        .awready     (awready),
        .awaddr      (awaddr),
        .wvalid      (wvalid),
        .wready      (wready),
        .wdata       (wdata),
        .arvalid     (arvalid),
        .arready     (arready),
        .araddr      (araddr),
        .rvalid      (rvalid),
        .rready      (rready),
        .rdata       (rdata),
        .start       (start),
        .data_length (data_length),
        .tap_num     (tap_num),
        .busy        (busy),
        .done        (done),
        .tap_idx     (tap_idx),
        .tap_coef    (tap_coef)
    );

    fir_sequencer #(
        .MAX_TAPS (MAX_TAPS)
    ) i_sequencer (
        .axis_clk    (axis_clk),
        .axis_rst_n  (axis_rst_n),
        .start       (start),
        .data_length (data_length),
        .tap_num     (tap_num),
        .busy        (busy),
        .done        (done),
        .tap_idx     (tap_idx),
        .ss_tvalid   (ss_tvalid),
        .ss_tdata    (ss_tdata),
        .ss_tready   (ss_tready),
        .sm_tvalid   (sm_tvalid),
        .sm_tready   (sm_tready),
        .sm_tlast    (sm_tlast),
        .step        (step),
        .first       (first),
        .hist_sample (hist_sample)
    );

    fir_mac i_mac (
        .axis_clk    (axis_clk),
        .axis_rst_n  (axis_rst_n),
        .step        (step),
        .first       (first),
        .tap_coef    (tap_coef),
        .hist_sample (hist_sample),
        .acc         (sm_tdata)
    );

endmodule

/* fir_checker.sv */
module fir_checker (
    input logic                       axis_clk,
    input logic                       axis_rst_n,
    input logic                       awvalid,
    input logic                       awready,
    input logic                       wvalid,
    input logic                       wready,
    input logic                       rvalid,
    input logic                       rready,
    input logic [fir_pkg::DATA_W-1:0] rdata,
    input logic                       ss_tready,
    input logic                       sm_tvalid,
    input logic                       sm_tready,
    input fir_pkg::acc_t              sm_tdata,
    input logic                       sm_tlast,
    input logic                       start
);

    // read by the testbench at the end of the run
    int   fail_cnt = 0;
    logic aw_seen;
    logic started;

    // --------------------
    // tracking
    // --------------------
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            aw_seen <= 1'b0;
            started <= 1'b0;
        end else begin
            if (awvalid && awready) begin
                aw_seen <= 1'b1;
            end else if (wvalid && wready) begin
                aw_seen <= 1'b0;
            end
            if (start) begin
                started <= 1'b1;
            end
        end
    end

    // --------------------
    // properties
    // --------------------
    sm_hold: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        sm_tvalid && !sm_tready |=> sm_tvalid && $stable(sm_tdata) && $stable(sm_tlast))
    else begin
        $error("output stream changed while stalled");
        fail_cnt++;
    end

    rd_hold: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata))
    else begin
        $error("read data changed before rready");
        fail_cnt++;
    end

    // write data phase only after an accepted address
    wr_order: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        wready |-> aw_seen)
    else begin
        $error("wready high with no pending write address");
        fail_cnt++;
    end

    quiet_idle: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        !started |-> !ss_tready && !sm_tvalid)
    else begin
        $error("stream strobes active before any start");
        fail_cnt++;
    end

endmodule

bind fir fir_checker i_checker (
    .axis_clk   (axis_clk),
    .axis_rst_n (axis_rst_n),
    .awvalid    (awvalid),
    .awready    (awready),
    .wvalid     (wvalid),
    .wready     (wready),
    .rvalid     (rvalid),
    .rready     (rready),
    .rdata      (rdata),
    .ss_tready  (ss_tready),
    .sm_tvalid  (sm_tvalid),
    .sm_tready  (sm_tready),
    .sm_tdata   (sm_tdata),
    .sm_tlast   (sm_tlast),
    .start      (start)
);

/* tb_fir.sv */
module tb_fir;
    import fir_pkg::*;

    localparam int MAX_TAPS = 32;
    localparam int WAIT_MAX = 2000;

    logic              axis_clk;
    logic              axis_rst_n;
    logic              awvalid;
    logic              awready;
    logic [ADDR_W-1:0] awaddr;
    logic              wvalid;
    logic              wready;
    logic [DATA_W-1:0] wdata;
    logic              arvalid;
    logic              arready;
    logic [ADDR_W-1:0] araddr;
    logic              rvalid;
    logic              rready;
    logic [DATA_W-1:0] rdata;
    logic              ss_tvalid;
    sample_t           ss_tdata;
    logic              ss_tready;
    logic              sm_tvalid;
    logic              sm_tready;
    acc_t              sm_tdata;
    logic              sm_tlast;

    logic [31:0]       seed = 32'h082d_dac0;
    coef_t             coefs [MAX_TAPS];
    sample_t           samples [$];
    int                err_cnt [6] = '{default: 0};
    int                check_cnt = 0;
    logic [DATA_W-1:0] busy_coef_rd;
    string             test_names [6] = '{"readback", "filter", "last_done",
                                          "second_run", "busy_block", "protocol"};

    fir #(
        .MAX_TAPS (MAX_TAPS)
    ) i_fir (.*);

    initial begin
        axis_clk = 1'b0;
        forever begin
            #2 axis_clk = ~axis_clk;
        end
    end

    // --------------------
    // helpers
    // --------------------
    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // y[n] with zero history before the run
    function automatic acc_t model_out(input int n, input int taps);
        acc_t sum;
        sum = '0;
        for (int i = 0; i < taps; i++) begin
            if (n - i >= 0) begin
                sum = sum + coefs[i] * samples[n - i];
            end
        end
        return sum;
    endfunction

    task automatic check_value(input int test, input string what,
                               input logic [31:0] exp, input logic [31:0] act);
        check_cnt++;
        assert (act === exp) else begin
            $display("FAIL %s (%s): expected %h, actual %h",
                     test_names[test], what, exp, act);
            err_cnt[test]++;
        end
    endtask

    task automatic abort_run(input string why);
        $display("timeout: %s", why);
        $display("TESTS FAILED");
        $finish;
    endtask

    task automatic report_test(input int test);
        $display("test %s: %s", test_names[test], (err_cnt[test] == 0) ? "ok" : "errors");
    endtask

    // --------------------
    // control port
    // --------------------
    task automatic reg_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        int t;
        @(negedge axis_clk);
        awvalid = 1'b1;
        awaddr  = addr;
        t = 0;
        while (!awready) begin
            @(negedge axis_clk);
            t++;
            if (t > WAIT_MAX) begin
                abort_run("write address never accepted");
            end
        end
        @(negedge axis_clk);
        awvalid = 1'b0;
        wvalid  = 1'b1;
        wdata   = data;
        t = 0;
        while (!wready) begin
            @(negedge axis_clk);
            t++;
            if (t > WAIT_MAX) begin
                abort_run("wready never rose");
            end
        end
        @(negedge axis_clk);
        wvalid = 1'b0;
    endtask

    task automatic reg_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
        int t;
        int hold;
        @(negedge axis_clk);
        arvalid = 1'b1;
        araddr  = addr;
        t = 0;
        while (!arready) begin
            @(negedge axis_clk);
            t++;
            if (t > WAIT_MAX) begin
                abort_run("read address never accepted");
            end
        end
        @(negedge axis_clk);
        arvalid = 1'b0;
        // short random stall on rready
        hold = int'(next_rand() % 32'd3);
        repeat (hold) @(negedge axis_clk);
        rready = 1'b1;
        t = 0;
        while (!rvalid) begin
            @(negedge axis_clk);
            t++;
            if (t > WAIT_MAX) begin
                abort_run("rvalid never rose");
            end
        end
        data = rdata;
        @(negedge axis_clk);
        rready = 1'b0;
    endtask

    task automatic wait_done(output logic [DATA_W-1:0] ctrl);
        int t;
        t = 0;
        reg_read(ADDR_CTRL, ctrl);
        while (!ctrl[CTRL_DONE]) begin
            t++;
            if (t > WAIT_MAX) begin
                abort_run("done bit never set");
            end
            reg_read(ADDR_CTRL, ctrl);
        end
    endtask

    // --------------------
    // streams
    // --------------------
    task automatic send_samples();
        int t;
        for (int n = 0; n < samples.size(); n++) begin
            ss_tvalid = 1'b1;
            ss_tdata  = samples[n];
            t = 0;
            while (!ss_tready) begin
                @(negedge axis_clk);
                t++;
                if (t > WAIT_MAX) begin
                    abort_run("ss_tready never rose");
                end
            end
            @(negedge axis_clk);
        end
        ss_tvalid = 1'b0;
    endtask

    task automatic collect_results(input int taps, input int data_test, input int last_test);
        int          t;
        logic        got_one;
        logic [31:0] rnd;
        for (int n = 0; n < samples.size(); n++) begin
            t = 0;
            got_one = 1'b0;
            while (!got_one) begin
                rnd = next_rand();
                sm_tready = rnd[9] | rnd[3];
                if (sm_tvalid && sm_tready) begin
                    check_value(data_test, "sm_tdata", model_out(n, taps), sm_tdata);
                    check_value(last_test, "sm_tlast", 32'(n == samples.size() - 1),
                                32'(sm_tlast));
                    got_one = 1'b1;
                end
                @(negedge axis_clk);
                t++;
                if (t > WAIT_MAX) begin
                    abort_run("no result on the output stream");
                end
            end
        end
        sm_tready = 1'b0;
    endtask

    // --------------------
    // tests
    // --------------------
    initial begin
        logic [DATA_W-1:0] rd;
        int                total;
        axis_rst_n = 1'b0;
        awvalid    = 1'b0;
        awaddr     = '0;
        wvalid     = 1'b0;
        wdata      = '0;
        arvalid    = 1'b0;
        araddr     = '0;
        rready     = 1'b0;
        ss_tvalid  = 1'b0;
        ss_tdata   = '0;
        sm_tready  = 1'b0;
        repeat (2) @(posedge axis_clk);
        @(negedge axis_clk);
        axis_rst_n = 1'b1;

        // register readback
        reg_read(ADDR_CTRL, rd);
        check_value(0, "ctrl after reset", 32'h4, rd);
        reg_write(ADDR_LEN, 32'd40);
        reg_write(ADDR_TAPS, 32'd11);
        for (int i = 0; i < MAX_TAPS; i++) begin
            coefs[i] = coef_t'(next_rand());
            reg_write(ADDR_COEF_BASE + ADDR_W'(4 * i), coefs[i]);
        end
        reg_read(ADDR_LEN, rd);
        check_value(0, "data_length", 32'd40, rd);
        reg_read(ADDR_TAPS, rd);
        check_value(0, "tap_num", 32'd11, rd);
        for (int i = 0; i < MAX_TAPS; i++) begin
            reg_read(ADDR_COEF_BASE + ADDR_W'(4 * i), rd);
            check_value(0, "coefficient", coefs[i], rd);
        end
        report_test(0);

        // first run, 11 taps
        samples.delete();
        for (int n = 0; n < 40; n++) begin
            samples.push_back(sample_t'(next_rand()));
        end
        reg_write(ADDR_CTRL, 32'h1);
        fork
            send_samples();
            collect_results(11, 1, 2);
        join
        report_test(1);
        wait_done(rd);
        check_value(2, "ctrl after run", 32'h6, rd);
        reg_read(ADDR_CTRL, rd);
        check_value(2, "ctrl second read", 32'h4, rd);
        report_test(2);

        // second run, 5 taps, with blocked accesses while busy
        samples.delete();
        for (int n = 0; n < 20; n++) begin
            samples.push_back(sample_t'(next_rand()));
        end
        reg_write(ADDR_TAPS, 32'd5);
        reg_write(ADDR_LEN, 32'd20);
        reg_write(ADDR_CTRL, 32'h1);
        fork
            send_samples();
            collect_results(5, 3, 3);
            begin
                reg_write(ADDR_COEF_BASE + ADDR_W'(12), 32'hdead_beef);
                reg_write(ADDR_LEN, 32'd99);
                reg_read(ADDR_COEF_BASE, busy_coef_rd);
            end
        join
        wait_done(rd);
        check_value(3, "ctrl after run", 32'h6, rd);
        report_test(3);

        check_value(4, "coefficient read while busy", 32'h0, busy_coef_rd);
        reg_read(ADDR_COEF_BASE + ADDR_W'(12), rd);
        check_value(4, "coefficient 3", coefs[3], rd);
        reg_read(ADDR_LEN, rd);
        check_value(4, "data_length", 32'd20, rd);
        report_test(4);

        check_value(5, "assertion failures", 32'd0, i_fir.i_checker.fail_cnt);
        report_test(5);

        total = 0;
        for (int i = 0; i < 6; i++) begin
            total += err_cnt[i];
        end
        $display("%0d checks, %0d failed", check_cnt, total);
        if (total == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* verilog.f */
fir_pkg.sv
fir_ram.sv
fir_regs.sv
fir_sequencer.sv
fir_mac.sv
fir.sv
fir_checker.sv
tb_fir.sv

/* run.sh */
#!/bin/sh
# build and run the fir testbench with verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --assert -Wno-fatal --top-module tb_fir -f verilog.f -o sim_fir
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

# keep running after an assertion error so the testbench reaches its verdict
./obj_dir/sim_fir +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTS FAILED" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
exit 0
